/* nf_pkg.sv */
`default_nettype none

package nf_pkg;

    localparam int NF_DATA_W  = 32;     // register width
    localparam int NF_ADDR_W  = 5;      // register address width
    localparam int NF_GPO_REG = 30;     // gpio output register, low 7 bits to led[7:1]
    localparam int NF_PWM_REG = 31;     // pwm duty register, low byte

    // active digit of the multiplexed display
    typedef enum logic [1 : 0] { DIG0, DIG1, DIG2, DIG3 } dig_sel_e;

    // nibble to segments, {dp,g,f,e,d,c,b,a}, common cathode
    function automatic logic [7 : 0] nf_seg_code(input logic [3 : 0] nib);
        logic [7 : 0] seg;
        case (nib)
            4'h0    : seg = 8'h3f;
            4'h1    : seg = 8'h06;
            4'h2    : seg = 8'h5b;
            4'h3    : seg = 8'h4f;
            4'h4    : seg = 8'h66;
            4'h5    : seg = 8'h6d;
            4'h6    : seg = 8'h7d;
            4'h7    : seg = 8'h07;
            4'h8    : seg = 8'h7f;
            4'h9    : seg = 8'h6f;
            4'ha    : seg = 8'h77;
            4'hb    : seg = 8'h7c;      // lower case b
            4'hc    : seg = 8'h39;
            4'hd    : seg = 8'h5e;      // lower case d
            4'he    : seg = 8'h79;
            default : seg = 8'h71;      // f
        endcase
        return seg;                     // dp stays dark
    endfunction

endpackage : nf_pkg

`default_nettype wire

/* nf_clk_div.sv */
`timescale 1ns/1ns
`default_nettype none

module nf_clk_div
#(
    parameter int DIV_LOW_BITS = 24                 // all-ones low bits of divide value
)
(
    input   logic   [0 : 0]     clk,                // clock
    input   logic   [0 : 0]     rst_n,              // async reset, active low
    input   logic   [2 : 0]     div_hi,             // upper bits of divide value
    output  logic   [0 : 0]     step                // one-cycle enable pulse
);

    localparam int DIV_W = DIV_LOW_BITS + 3;        // full divide width

    logic   [DIV_W-1 : 0]   div_val;                // terminal count
    logic   [DIV_W-1 : 0]   cnt;                    // free counter

    assign div_val = { div_hi , {DIV_LOW_BITS{1'b1}} };

    // period is div_val + 1 cycles
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            cnt  <= '0;
            step <= 1'b0;
        end
        else if (cnt >= div_val)                    // also catches a lowered div_hi
        begin
            cnt  <= '0;                             // restart
            step <= 1'b1;
        end
        else
        begin
            cnt  <= cnt + 1'b1;
            step <= 1'b0;
        end
    end

endmodule : nf_clk_div

`default_nettype wire

/* nf_reg_file.sv */
`timescale 1ns/1ns
`default_nettype none

module nf_reg_file
    import nf_pkg::*;
(
    input   logic   [0 : 0]             clk,        // clock
    input   logic   [0 : 0]             rst_n,      // async reset, active low
    input   logic   [0 : 0]             wr_en,      // write strobe
    input   logic   [NF_ADDR_W-1 : 0]   wr_addr,    // write address
    input   logic   [NF_DATA_W-1 : 0]   wr_data,    // write data
    input   logic   [NF_ADDR_W-1 : 0]   scan_addr,  // debug scan address
    output  logic   [NF_DATA_W-1 : 0]   scan_data,  // debug scan data
    output  logic   [6 : 0]             gpo,        // gpio output bits
    output  logic   [7 : 0]             pwm_duty    // pwm duty byte
);

    localparam int NF_REGS = 2 ** NF_ADDR_W;        // register count

    logic   [NF_DATA_W-1 : 0]   regs [0 : NF_REGS-1];   // register bank

    // single write port, stands in for core writeback
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < NF_REGS; i++)
                regs[i] <= '0;                      // whole bank cleared
        end
        else if (wr_en && (wr_addr != '0))          // r0 is hardwired zero
        begin
            regs[wr_addr] <= wr_data;
        end
    end

    // scan read, no latency
    assign scan_data = regs[scan_addr];

    // peripheral taps
    assign gpo      = regs[NF_GPO_REG][6 : 0];      // to led[7:1]
    assign pwm_duty = regs[NF_PWM_REG][7 : 0];      // duty byte

endmodule : nf_reg_file

`default_nettype wire

/* nf_pwm.sv */
`timescale 1ns/1ns
`default_nettype none

module nf_pwm
(
    input   logic   [0 : 0]     clk,            // clock
    input   logic   [0 : 0]     rst_n,          // async reset, active low
    input   logic   [7 : 0]     duty,           // high cycles per 256
    output  logic   [0 : 0]     pwm             // pwm output
);

    logic   [7 : 0]     cnt;                    // wrapping phase counter

    // 0 -> never high, 255 -> high 255 of 256
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            cnt <= '0;
            pwm <= 1'b0;
        end
        else
        begin
            cnt <= cnt + 1'b1;                  // wraps 255 -> 0
            pwm <= (cnt < duty);                // registered compare
        end
    end

endmodule : nf_pwm

`default_nettype wire

/* nf_seven_seg_dynamic.sv */
`timescale 1ns/1ns
`default_nettype none

module nf_seven_seg_dynamic
    import nf_pkg::*;
(
    input   logic   [0  : 0]    clk,            // clock
    input   logic   [0  : 0]    rst_n,          // async reset, active low
    input   logic   [0  : 0]    step,           // digit advance enable
    input   logic   [15 : 0]    hex,            // four nibbles to show
    output  logic   [7  : 0]    seven_seg,      // segment pattern
    output  logic   [3  : 0]    dig             // one-hot digit select
);

    dig_sel_e           sel;                    // active digit
    dig_sel_e           sel_nxt;                // digit after step
    logic   [3 : 0]     nib;                    // nibble of active digit
    logic   [3 : 0]     dig_oh;                 // one-hot of active digit

    // decode active digit
    always_comb
    begin
        unique case (sel)
            DIG0 :
            begin
                sel_nxt = DIG1;
                nib     = hex[3 : 0];
                dig_oh  = 4'b0001;
            end
            DIG1 :
            begin
                sel_nxt = DIG2;
                nib     = hex[7 : 4];
                dig_oh  = 4'b0010;
            end
            DIG2 :
            begin
                sel_nxt = DIG3;
                nib     = hex[11 : 8];
                dig_oh  = 4'b0100;
            end
            default :
            begin
                sel_nxt = DIG0;                 // wrap to first digit
                nib     = hex[15 : 12];
                dig_oh  = 4'b1000;
            end
        endcase
    end

    // digit rotation
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            sel <= DIG0;
        else if (step)
            sel <= sel_nxt;
    end

    // output stage, select and segments move together
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            dig       <= 4'b0001;
            seven_seg <= nf_seg_code(4'h0);     // bank is zero after reset
        end
        else
        begin
            dig       <= dig_oh;
            seven_seg <= nf_seg_code(nib);
        end
    end

endmodule : nf_seven_seg_dynamic

`default_nettype wire

/* nf_board_top.sv */
`timescale 1ns/1ns
`default_nettype none

module nf_board_top
    import nf_pkg::*;
#(
    parameter int DIV_LOW_BITS = 24                     // 24 on the board
)
(
    input   logic   [0 : 0]             clk50mhz,       // board clock
    input   logic   [0 : 0]             rst_n,          // async reset, active low
    input   logic   [3 : 0]             key,            // scan address low bits
    input   logic   [3 : 0]             sw,             // sw[0] scan msb, sw[3:1] divider
    input   logic   [0 : 0]             wr_en,          // write strobe
    input   logic   [NF_ADDR_W-1 : 0]   wr_addr,        // write address
    input   logic   [NF_DATA_W-1 : 0]   wr_data,        // write data
    output  logic   [7 : 0]             led,            // gpo and pwm
    output  logic   [7 : 0]             hex0,           // segments
    output  logic   [0 : 0]             g,              // dig[1]
    output  logic   [0 : 0]             b,              // dig[0]
    output  logic   [0 : 0]             hsync,          // dig[2]
    output  logic   [0 : 0]             vsync           // dig[3]
);

    logic   [NF_ADDR_W-1 : 0]   scan_addr;              // scan register address
    logic   [NF_DATA_W-1 : 0]   scan_data;              // scan register data
    logic   [6 : 0]             gpo;                    // gpio output
    logic   [7 : 0]             pwm_duty;               // duty byte
    logic   [0 : 0]             pwm;                    // pwm output
    logic   [0 : 0]             step;                   // digit advance
    logic   [7 : 0]             seven_seg;              // segment pattern
    logic   [3 : 0]             dig;                    // digit select

    assign scan_addr   = { sw[0] , key[0 +: 4] };
    assign led[1 +: 7] = gpo;
    assign led[0 +: 1] = pwm;
    assign hex0        = seven_seg;
    assign b           = dig[0];
    assign g           = dig[1];
    assign hsync       = dig[2];
    assign vsync       = dig[3];

    nf_clk_div #(
        .DIV_LOW_BITS   ( DIV_LOW_BITS  )
    ) nf_clk_div_0 (
        .clk            ( clk50mhz      ),
        .rst_n          ( rst_n         ),
        .div_hi         ( sw[1 +: 3]    ),              // divide value high bits
        .step           ( step          )
    );

    nf_reg_file nf_reg_file_0 (
        .clk            ( clk50mhz      ),
        .rst_n          ( rst_n         ),
        .wr_en          ( wr_en         ),
        .wr_addr        ( wr_addr       ),
        .wr_data        ( wr_data       ),
        .scan_addr      ( scan_addr     ),
        .scan_data      ( scan_data     ),
        .gpo            ( gpo           ),
        .pwm_duty       ( pwm_duty      )
    );

    nf_pwm nf_pwm_0 (
        .clk            ( clk50mhz      ),
        .rst_n          ( rst_n         ),
        .duty           ( pwm_duty      ),
        .pwm            ( pwm           )
    );

    nf_seven_seg_dynamic nf_seven_seg_dynamic_0 (
        .clk            ( clk50mhz          ),
        .rst_n          ( rst_n             ),
        .step           ( step              ),
        .hex            ( scan_data[15 : 0] ),          // low half only
        .seven_seg      ( seven_seg         ),
        .dig            ( dig               )
    );

endmodule : nf_board_top

`default_nettype wire

/* tb_nf_board.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_nf_board
    import nf_pkg::*;
;

    typedef enum logic [1 : 0] { WRITE, SCAN, PWM, END } vec_op_e;  // vectors file opcodes

    localparam int VEC_MAX = 64;                        // vector slots
    localparam int N_RAND  = 8;                         // extra random write/scan pairs
    localparam int N_SWEEP = 4;                         // nibble sweep write/scan pairs

    logic                       clk = 1'b0;
    logic                       rst_n;
    logic   [3 : 0]             key;
    logic   [3 : 0]             sw;
    logic                       wr_en;
    logic   [NF_ADDR_W-1 : 0]   wr_addr;
    logic   [NF_DATA_W-1 : 0]   wr_data;
    logic   [7 : 0]             led;
    logic   [7 : 0]             hex0;
    logic                       g;
    logic                       b;
    logic                       hsync;
    logic                       vsync;

    logic   [31 : 0]            vec_mem [0 : 3*VEC_MAX-1];  // op, field, value per line
    logic   [NF_DATA_W-1 : 0]   model   [0 : 31];           // expected register bank
    int                         cycles = 0;
    int                         limit  = 0;
    integer                     seed;

    nf_board_top #(
        .DIV_LOW_BITS   ( 2         )
    ) dut0 (
        .clk50mhz       ( clk       ),
        .rst_n          ( rst_n     ),
        .key            ( key       ),
        .sw             ( sw        ),
        .wr_en          ( wr_en     ),
        .wr_addr        ( wr_addr   ),
        .wr_data        ( wr_data   ),
        .led            ( led       ),
        .hex0           ( hex0      ),
        .g              ( g         ),
        .b              ( b         ),
        .hsync          ( hsync     ),
        .vsync          ( vsync     )
    );

    always #4 clk = ~clk;                               // 8 ns period

    always @(posedge clk)
    begin
        cycles <= cycles + 1;
        if (cycles > limit)
        begin
            $display("timeout: display or pwm checks never completed");
            stop_run();
        end
    end

    task automatic stop_run();
        $display("Simulation failed");
        $fatal(1, "stopped at first failure");
    endtask

    // common cathode shapes in {dp,g,f,e,d,c,b,a} order
    function automatic logic [7 : 0] seg_ref(input logic [3 : 0] n);
        logic [7 : 0] tbl [0 : 15];
        tbl = '{8'h3f, 8'h06, 8'h5b, 8'h4f, 8'h66, 8'h6d, 8'h7d, 8'h07,
                8'h7f, 8'h6f, 8'h77, 8'h7c, 8'h39, 8'h5e, 8'h79, 8'h71};
        return tbl[n];
    endfunction

    task automatic check_seg(input dig_sel_e d, input logic [7 : 0] exp_v,
                             input logic [7 : 0] obs);
        if (obs !== exp_v)
        begin
            $display("ERROR hex0 on %s: expected %h, got %h", d.name(), exp_v, obs);
            stop_run();
        end
    endtask

    task automatic check_led(input logic [7 : 0] exp_v, input logic [7 : 0] obs);
        if (obs !== exp_v)
        begin
            $display("ERROR led: expected %h, got %h", exp_v, obs);
            stop_run();
        end
    endtask

    task automatic check_count(input logic [8 : 0] exp_v, input logic [8 : 0] obs);
        if (obs !== exp_v)
        begin
            $display("ERROR led[0] high count: expected %h, got %h", exp_v, obs);
            stop_run();
        end
    endtask

    task automatic check_gap(input int exp_v, input int obs);
        if (obs != exp_v)
        begin
            $display("ERROR digit step spacing: expected %h, got %h", exp_v, obs);
            stop_run();
        end
    endtask

    // one-hot pins back to digit
    task automatic decode_dig(input logic [3 : 0] oh, output dig_sel_e d);
        case (oh)
            4'b0001 : d = DIG0;
            4'b0010 : d = DIG1;
            4'b0100 : d = DIG2;
            4'b1000 : d = DIG3;
            default :
            begin
                $display("digit select pins are not one-hot: %b", oh);
                stop_run();
            end
        endcase
    endtask

    task automatic write_reg(input logic [4 : 0] a, input logic [31 : 0] d);
        @(posedge clk);
        #1;
        wr_en   = 1'b1;
        wr_addr = a;
        wr_data = d;
        @(posedge clk);                                 // write edge
        #1;
        wr_en = 1'b0;
        if (a != 5'd0)
            model[a] = d;                               // r0 never changes
        @(negedge clk);
        check_led({model[NF_GPO_REG][6 : 0], 1'b0}, {led[7 : 1], 1'b0});
    endtask

    // fld packs sw[3:1] and sw[0] above key
    // one switch change, then five digit changes watched
    task automatic scan_check(input logic [7 : 0] fld, input logic [31 : 0] exp_v);
        logic [3 : 0]   prev;
        int             t_prev;
        int             seen;
        int             gap;
        dig_sel_e       d;
        @(posedge clk);
        #1;
        key = fld[3 : 0];
        sw  = fld[7 : 4];
        @(posedge clk);                                 // output stage picks up new register
        @(negedge clk);
        gap    = fld[7 : 5] * 4 + 4;                    // divide value {k,2'b11} plus one
        prev   = {vsync, hsync, g, b};
        seen   = 0;
        t_prev = 0;
        while (seen < 5)
        begin
            decode_dig({vsync, hsync, g, b}, d);
            check_seg(d, seg_ref(exp_v[4*d +: 4]), hex0);
            if ({vsync, hsync, g, b} != prev)
            begin
                if (seen > 0)
                    check_gap(gap, cycles - t_prev);
                t_prev = cycles;
                prev   = {vsync, hsync, g, b};
                seen++;
            end
            @(negedge clk);
        end
    endtask

    task automatic pwm_check(input logic [7 : 0] duty);
        logic [8 : 0] high;
        write_reg(NF_PWM_REG, {24'h0, duty});
        repeat (256) @(posedge clk);                    // let one full period pass
        high = '0;
        repeat (256)
        begin
            @(negedge clk);
            high = high + led[0];
        end
        check_count({1'b0, duty}, high);
    endtask

    initial
    begin
        int             n_vec;
        int             n_pwm;
        logic [4:0]     ra;
        logic [15:0]    sweep;
        vec_op_e        op;
        seed    = 32'he34b;
        rst_n   = 1'b0;
        key     = '0;
        sw      = '0;
        wr_en   = 1'b0;
        wr_addr = '0;
        wr_data = '0;
        for (int i = 0; i < 32; i++)
            model[i] = '0;
        $readmemh("nf_board_vectors.txt", vec_mem);
        n_vec = 0;
        n_pwm = 0;
        while (n_vec < VEC_MAX && vec_mem[3*n_vec] !== 32'(END))
        begin
            if (vec_mem[3*n_vec] === 32'(PWM))
                n_pwm++;
            n_vec++;
        end
        limit = (n_vec + 2 * (N_RAND + N_SWEEP)) * 64 + n_pwm * 256 + 1000;
        repeat (16) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(negedge clk);
        check_led(8'h00, led);
        if ({vsync, hsync, g, b} !== 4'b0001)
        begin
            $display("ERROR dig: expected %h, got %h", 4'h1, {vsync, hsync, g, b});
            stop_run();
        end
        check_seg(DIG0, seg_ref(4'h0), hex0);
        for (int vi = 0; vi < n_vec; vi++)
        begin
            op = vec_op_e'(vec_mem[3*vi][1 : 0]);
            case (op)
                WRITE   : write_reg(vec_mem[3*vi+1][4 : 0], vec_mem[3*vi+2]);
                SCAN    : scan_check(vec_mem[3*vi+1][7 : 0], vec_mem[3*vi+2]);
                PWM     : pwm_check(vec_mem[3*vi+2][7 : 0]);
                default :
                begin
                    $display("unknown opcode in vectors file at line %0d", vi);
                    stop_run();
                end
            endcase
        end
        for (int i = 0; i < N_SWEEP; i++)
        begin
            sweep = 16'h3210 + 16'h4444 * i;            // every nibble 0 to f once
            write_reg(5'd2, {16'h0, sweep});
            scan_check(8'h02, {16'h0, sweep});
        end
        for (int i = 0; i < N_RAND; i++)
        begin
            ra = 5'(1 + ($unsigned($random(seed)) % 29));   // keeps off r0 and the gpo and pwm regs
            write_reg(ra, $random(seed));
            scan_check({3'b000, ra}, model[ra]);
        end
        $display("Simulation passed");
        $finish;
    end

endmodule : tb_nf_board

`default_nettype wire

/* nf_board_vectors.txt */
// columns: opcode (0 write, 1 scan, 2 pwm, 3 end), field, value
// write: field = reg, value = data; scan: field = {sw[3:1],sw[0],key}, value = expected
0 05 12345678
1 05 12345678
0 11 9abcdef0
1 31 9abcdef0
0 1e 0000007f
0 0a 00000055
1 1e 0000007f
0 00 deadbeef
1 00 00000000
0 03 0000fedc
1 63 0000fedc
0 07 00003210
1 47 00003210
0 1e 0000002a
1 fe 0000002a
2 1f 00000000
2 1f 00000001
2 1f 00000080
2 1f 000000ff
3 00 00000000

/* sim.f */
nf_pkg.sv
nf_clk_div.sv
nf_reg_file.sv
nf_pwm.sv
nf_seven_seg_dynamic.sv
nf_board_top.sv
tb_nf_board.sv

/* Bender.yml */
package:
  name: nf_board

sources:
  - nf_pkg.sv
  - nf_clk_div.sv
  - nf_reg_file.sv
  - nf_pwm.sv
  - nf_seven_seg_dynamic.sv
  - nf_board_top.sv
  - target: simulation
    files:
      - tb_nf_board.sv
